//--- vseq_pkg.sv
// Shared sizes, enums and packed structs of the vector sequencer, used by RTL and testbench
package vseq_pkg;

  //////////////////////////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////////////////////////

  // Instruction IDs that can be in flight at once
  localparam int unsigned NR_VINSN     = 8;
  // Architectural vector registers
  localparam int unsigned NR_VREGS     = 32;
  // ALU, multiplier, load unit and store unit
  localparam int unsigned NR_UNITS     = 4;
  // Credits each unit holds out of reset
  localparam int unsigned UNIT_CREDITS = 2;

  localparam int unsigned VID_W  = $clog2(NR_VINSN);
  localparam int unsigned VREG_W = $clog2(NR_VREGS);

  //////////////////////////////////////////////////////////////////////
  // Scalar types
  //////////////////////////////////////////////////////////////////////

  typedef logic [VID_W-1:0]    vid_t;
  typedef logic [VREG_W-1:0]   vreg_t;
  typedef logic [1:0]          credit_t;
  // One bit per instruction ID
  typedef logic [NR_VINSN-1:0] vmask_t;

  // Functional units, value doubles as index into per-unit arrays
  typedef enum logic [1:0] {
    UNIT_ALU,
    UNIT_MUL,
    UNIT_LOAD,
    UNIT_STORE
  } unit_e;

  // Operations, grouped in ranges per unit
  typedef enum logic [3:0] {
    VADD,
    VSUB,
    VAND,
    VOR,
    VMUL,
    VMACC,
    VLE,
    VSE,
    VMVSX
  } vop_e;

  //////////////////////////////////////////////////////////////////////
  // Structs
  //////////////////////////////////////////////////////////////////////

  // Request from the dispatcher
  typedef struct packed {
    vop_e  op;
    vreg_t vs1;
    logic  use_vs1;
    vreg_t vs2;
    logic  use_vs2;
    vreg_t vd;
    logic  use_vd;
  } vseq_req_t;

  // Instruction issued to a functional unit
  typedef struct packed {
    vid_t   id;
    vop_e   op;
    unit_e  unit;
    vreg_t  vs1;
    logic   use_vs1;
    vreg_t  vs2;
    logic   use_vs2;
    vreg_t  vd;
    logic   use_vd;
    vmask_t hazard;
  } vseq_issue_t;

  // Completion report from one unit
  typedef struct packed {
    logic valid;
    vid_t id;
  } unit_done_t;

  // Last reader or last writer of one vector register
  typedef struct packed {
    vid_t vid;
    logic valid;
  } vreg_entry_t;

endpackage

//--- vid_tracker.sv
// Keeps the set of running instruction IDs, offers the lowest free ID and flags idle
`timescale 1ns/1ps

module vid_tracker (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Allocation of the offered ID on accept
  input  logic                                          alloc_i,
  input  vseq_pkg::vid_t                                alloc_id_i,
  // Completions, one slot per unit
  input  vseq_pkg::unit_done_t [vseq_pkg::NR_UNITS-1:0] done_i,
  // Lowest free ID and status
  output vseq_pkg::vid_t                                next_id_o,
  output logic                                          full_o,
  output vseq_pkg::vmask_t                              running_o,
  output logic                                          idle_o
);

  // Set bit means the ID is in flight somewhere
  vseq_pkg::vmask_t running_d, running_q;

  vseq_pkg::vid_t free_id;
  logic           free_found;

  //////////////////////////////////////////////////////////////////////
  // Free ID search
  //////////////////////////////////////////////////////////////////////

  // Zero search from the top down so the last hit is the lowest clear bit
  always_comb begin : p_free_search
    free_id    = '0;
    free_found = 1'b0;
    for (int i = vseq_pkg::NR_VINSN - 1; i >= 0; i--) begin
      if (!running_q[i]) begin
        free_id    = vseq_pkg::vid_t'(i);
        free_found = 1'b1;
      end
    end
  end

  assign next_id_o = free_id;
  // No clear bit left
  assign full_o    = !free_found;

  //////////////////////////////////////////////////////////////////////
  // Running bitmap
  //////////////////////////////////////////////////////////////////////

  always_comb begin : p_running_next
    running_d = running_q;
    // Completions free their IDs
    for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
      if (done_i[u].valid) begin
        running_d[done_i[u].id] = 1'b0;
      end
    end
    // A new ID is always a free one, so it never collides with a completion
    if (alloc_i) begin
      running_d[alloc_id_i] = 1'b1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_running_ff
    if (!rst_ni) begin
      running_q <= '0;
    end else begin
      running_q <= running_d;
    end
  end

  assign running_o = running_q;
  // Idle straight from the registered bitmap
  assign idle_o    = ~|running_q;

endmodule

//--- reg_scoreboard.sv
// Per-register last reader and last writer lists, giving the hazard vector of the current request
`timescale 1ns/1ps

module reg_scoreboard (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  // Request under evaluation
  input  vseq_pkg::vseq_req_t   req_i,
  // Accept strobe and the ID given to the request
  input  logic                  accept_i,
  input  vseq_pkg::vid_t        accept_id_i,
  // IDs still in flight
  input  vseq_pkg::vmask_t      running_i,
  // Running IDs the request depends on
  output vseq_pkg::vmask_t      hazard_o
);

  // Stored lists
  vseq_pkg::vreg_entry_t [vseq_pkg::NR_VREGS-1:0] read_list_d, read_list_q;
  vseq_pkg::vreg_entry_t [vseq_pkg::NR_VREGS-1:0] write_list_d, write_list_q;

  // Lists with finished IDs dropped
  vseq_pkg::vreg_entry_t [vseq_pkg::NR_VREGS-1:0] read_live, write_live;

  // Entries looked up for the request
  vseq_pkg::vreg_entry_t vs1_writer, vs2_writer, vd_reader, vd_writer;

  //////////////////////////////////////////////////////////////////////
  // Entry validity
  //////////////////////////////////////////////////////////////////////

  // An entry only counts while its ID is running
  always_comb begin : p_live
    for (int v = 0; v < vseq_pkg::NR_VREGS; v++) begin
      read_live[v]        = read_list_q[v];
      read_live[v].valid  = read_list_q[v].valid & running_i[read_list_q[v].vid];
      write_live[v]       = write_list_q[v];
      write_live[v].valid = write_list_q[v].valid & running_i[write_list_q[v].vid];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Hazard vector
  //////////////////////////////////////////////////////////////////////

  assign vs1_writer = write_live[req_i.vs1];
  assign vs2_writer = write_live[req_i.vs2];
  assign vd_reader  = read_live[req_i.vd];
  assign vd_writer  = write_live[req_i.vd];

  always_comb begin : p_hazard
    hazard_o = '0;
    // Read after write on the used sources
    if (req_i.use_vs1 && vs1_writer.valid) begin
      hazard_o[vs1_writer.vid] = 1'b1;
    end
    if (req_i.use_vs2 && vs2_writer.valid) begin
      hazard_o[vs2_writer.vid] = 1'b1;
    end
    // Write after read on the destination
    if (req_i.use_vd && vd_reader.valid) begin
      hazard_o[vd_reader.vid] = 1'b1;
    end
    // Write after write on the destination
    if (req_i.use_vd && vd_writer.valid) begin
      hazard_o[vd_writer.vid] = 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // List update
  //////////////////////////////////////////////////////////////////////

  // Stale entries are cleared so a reused ID never revives them
  always_comb begin : p_list_next
    read_list_d  = read_live;
    write_list_d = write_live;
    if (accept_i) begin
      if (req_i.use_vd) begin
        write_list_d[req_i.vd] = '{vid: accept_id_i, valid: 1'b1};
      end
      if (req_i.use_vs1) begin
        read_list_d[req_i.vs1] = '{vid: accept_id_i, valid: 1'b1};
      end
      if (req_i.use_vs2) begin
        read_list_d[req_i.vs2] = '{vid: accept_id_i, valid: 1'b1};
      end
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_list_ff
    if (!rst_ni) begin
      read_list_q  <= '0;
      write_list_q <= '0;
    end else begin
      read_list_q  <= read_list_d;
      write_list_q <= write_list_d;
    end
  end

endmodule

//--- unit_credits.sv
// Credit counters for the functional units, spent on accept and returned on completion
`timescale 1ns/1ps

module unit_credits (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Accepted instruction and its unit
  input  logic                                          issue_i,
  input  vseq_pkg::unit_e                               issue_unit_i,
  // Each valid completion returns one credit
  input  vseq_pkg::unit_done_t [vseq_pkg::NR_UNITS-1:0] done_i,
  // Unit can take at least one more instruction
  output logic [vseq_pkg::NR_UNITS-1:0]                 has_credit_o
);

  //////////////////////////////////////////////////////////////////////
  // One counter per unit
  //////////////////////////////////////////////////////////////////////

  for (genvar u = 0; u < vseq_pkg::NR_UNITS; u++) begin : gen_credit
    vseq_pkg::credit_t credit_q;
    logic              take;
    logic              give;

    // Spend on an accept aimed at this unit
    assign take = issue_i && (issue_unit_i == vseq_pkg::unit_e'(u));
    assign give = done_i[u].valid;

    // Spend and return in one cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin : p_credit_ff
      if (!rst_ni) begin
        credit_q <= vseq_pkg::credit_t'(vseq_pkg::UNIT_CREDITS);
      end else if (take && !give) begin
        credit_q <= credit_q - vseq_pkg::credit_t'(1);
      end else if (give && !take) begin
        credit_q <= credit_q + vseq_pkg::credit_t'(1);
      end
    end

    assign has_credit_o[u] = |credit_q;
  end

endmodule

//--- issue_ctrl.sv
// Decodes the target unit, applies the stall rules and registers the instruction sent to the units
`timescale 1ns/1ps

module issue_ctrl (
  input  logic                          clk_i,
  input  logic                          rst_ni,
  // Dispatcher handshake
  input  vseq_pkg::vseq_req_t           req_i,
  input  logic                          req_valid_i,
  output logic                          req_ready_o,
  // State of tracker, credits and scoreboard
  input  vseq_pkg::vid_t                next_id_i,
  input  logic                          full_i,
  input  logic [vseq_pkg::NR_UNITS-1:0] has_credit_i,
  input  vseq_pkg::vmask_t              hazard_i,
  // Accept strobe to the bookkeeping blocks
  output logic                          accept_o,
  output vseq_pkg::unit_e               accept_unit_o,
  // Issue channel to the units
  output vseq_pkg::vseq_issue_t         issue_o,
  output logic                          issue_valid_o
);

  // Operation ranges per unit
  function automatic vseq_pkg::unit_e unit_of(vseq_pkg::vop_e op);
    case (op) inside
      [vseq_pkg::VADD:vseq_pkg::VOR]: unit_of = vseq_pkg::UNIT_ALU;
      vseq_pkg::VMVSX:                unit_of = vseq_pkg::UNIT_ALU;
      [vseq_pkg::VMUL:vseq_pkg::VMACC]: unit_of = vseq_pkg::UNIT_MUL;
      vseq_pkg::VLE:                  unit_of = vseq_pkg::UNIT_LOAD;
      vseq_pkg::VSE:                  unit_of = vseq_pkg::UNIT_STORE;
      default:                        unit_of = vseq_pkg::UNIT_ALU;
    endcase
  endfunction

  vseq_pkg::unit_e       req_unit;
  logic                  no_operand_hazard;
  vseq_pkg::vseq_issue_t issue_q;
  logic                  issue_valid_q;

  //////////////////////////////////////////////////////////////////////
  // Ready rule
  //////////////////////////////////////////////////////////////////////

  assign req_unit = unit_of(req_i.op);

  // Without vector sources there is no operand path to chain on, so wait out any hazard
  assign no_operand_hazard = !req_i.use_vs1 && !req_i.use_vs2 && (|hazard_i);

  // Free ID, a credit at the target unit and no blocked no-operand case
  assign req_ready_o   = !full_i && has_credit_i[req_unit] && !no_operand_hazard;
  assign accept_o      = req_valid_i && req_ready_o;
  assign accept_unit_o = req_unit;

  //////////////////////////////////////////////////////////////////////
  // Issue register
  //////////////////////////////////////////////////////////////////////

  // One-cycle pulse after each accept
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_issue_valid_ff
    if (!rst_ni) begin
      issue_valid_q <= 1'b0;
    end else begin
      issue_valid_q <= accept_o;
    end
  end

  // Payload only loads on accept
  always_ff @(posedge clk_i) begin : p_issue_ff
    if (accept_o) begin
      issue_q <= '{
        id:      next_id_i,
        op:      req_i.op,
        unit:    req_unit,
        vs1:     req_i.vs1,
        use_vs1: req_i.use_vs1,
        vs2:     req_i.vs2,
        use_vs2: req_i.use_vs2,
        vd:      req_i.vd,
        use_vd:  req_i.use_vd,
        hazard:  hazard_i
      };
    end
  end

  assign issue_o       = issue_q;
  assign issue_valid_o = issue_valid_q;

endmodule

//--- vseq_top.sv
// Top level of the vector sequencer, joining ID tracker, scoreboard, credits and issue control
`timescale 1ns/1ps

module vseq_top (
  input  logic                                          clk_i,
  input  logic                                          rst_ni,
  // Dispatcher side
  input  vseq_pkg::vseq_req_t                           req_i,
  input  logic                                          req_valid_i,
  output logic                                          req_ready_o,
  // Unit side
  output vseq_pkg::vseq_issue_t                         issue_o,
  output logic                                          issue_valid_o,
  input  vseq_pkg::unit_done_t [vseq_pkg::NR_UNITS-1:0] done_i,
  // Nothing in flight
  output logic                                          idle_o
);

  //////////////////////////////////////////////////////////////////////
  // Internal nets
  //////////////////////////////////////////////////////////////////////

  logic                          accept;
  vseq_pkg::unit_e               accept_unit;
  vseq_pkg::vid_t                next_id;
  logic                          full;
  vseq_pkg::vmask_t              running;
  vseq_pkg::vmask_t              hazard;
  logic [vseq_pkg::NR_UNITS-1:0] has_credit;

  //////////////////////////////////////////////////////////////////////
  // Blocks
  //////////////////////////////////////////////////////////////////////

  // Running IDs, the offered ID is the one allocated on accept
  vid_tracker i_vid_tracker (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .alloc_i    (accept),
    .alloc_id_i (next_id),
    .done_i     (done_i),
    .next_id_o  (next_id),
    .full_o     (full),
    .running_o  (running),
    .idle_o     (idle_o)
  );

  // Register lists and hazard vector
  reg_scoreboard i_reg_scoreboard (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .accept_i    (accept),
    .accept_id_i (next_id),
    .running_i   (running),
    .hazard_o    (hazard)
  );

  // Flow control toward the units
  unit_credits i_unit_credits (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .issue_i      (accept),
    .issue_unit_i (accept_unit),
    .done_i       (done_i),
    .has_credit_o (has_credit)
  );

  issue_ctrl i_issue_ctrl (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .next_id_i     (next_id),
    .full_i        (full),
    .has_credit_i  (has_credit),
    .hazard_i      (hazard),
    .accept_o      (accept),
    .accept_unit_o (accept_unit),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o)
  );

endmodule

//--- vseq_properties.sv
// Concurrent assertions on credits, ID allocation and ready, bound into the sequencer top level
`timescale 1ns/1ps

module vseq_properties (
  input logic                                          clk_i,
  input logic                                          rst_ni,
  input logic                                          accept_i,
  input vseq_pkg::unit_e                               accept_unit_i,
  input vseq_pkg::unit_done_t [vseq_pkg::NR_UNITS-1:0] done_i,
  input vseq_pkg::vid_t                                next_id_i,
  input vseq_pkg::vmask_t                              running_i,
  input logic                                          req_ready_i
);

  // Instructions held by each unit, counted from accepts and completions
  int in_flight [vseq_pkg::NR_UNITS];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_in_flight
    if (!rst_ni) begin
      for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
        in_flight[u] <= 0;
      end
    end else begin
      for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
        in_flight[u] <= in_flight[u]
                        + ((accept_i && (accept_unit_i == vseq_pkg::unit_e'(u))) ? 1 : 0)
                        - (done_i[u].valid ? 1 : 0);
      end
    end
  end

  // Target unit must still have room when an instruction is accepted
  a_credit_on_issue : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i |-> (in_flight[accept_unit_i] < int'(vseq_pkg::UNIT_CREDITS)))
    else $error("Issue to a unit without credit");

  // Allocated ID was free
  a_free_id : assert property (@(posedge clk_i) disable iff (!rst_ni)
    accept_i |-> !running_i[next_id_i])
    else $error("Issued ID was already running");

  // No handshake while every ID is in flight
  a_full_stall : assert property (@(posedge clk_i) disable iff (!rst_ni)
    (&running_i) |-> !req_ready_i)
    else $error("Ready high while the ID tracker is full");

endmodule

bind vseq_top vseq_properties i_vseq_properties (
  .clk_i         (clk_i),
  .rst_ni        (rst_ni),
  .accept_i      (accept),
  .accept_unit_i (accept_unit),
  .done_i        (done_i),
  .next_id_i     (next_id),
  .running_i     (running),
  .req_ready_i   (req_ready_o)
);

//--- tb_vseq.sv
// Testbench driving random requests into the vector sequencer against a reference model, built from flist.f
`timescale 1ns/1ps

module tb_vseq;

  // Run length and timing
  localparam int unsigned NR_REQ         = 400;
  localparam int unsigned TIMEOUT_CYCLES = NR_REQ * 16;
  localparam int unsigned RESET_CYCLES   = 5;
  localparam time         HALF_PERIOD    = 20ns;
  localparam time         DRIVE_DELAY    = 2ns;

  // Instruction held by a unit model until its completion cycle
  typedef struct packed {
    vseq_pkg::unit_e unit;
    vseq_pkg::vid_t  id;
    logic [31:0]     due;
  } pending_t;

  logic                                          clk_i;
  logic                                          rst_ni;
  vseq_pkg::vseq_req_t                           req_i;
  logic                                          req_valid_i;
  logic                                          req_ready_o;
  vseq_pkg::vseq_issue_t                         issue_o;
  logic                                          issue_valid_o;
  vseq_pkg::unit_done_t [vseq_pkg::NR_UNITS-1:0] done_i;
  logic                                          idle_o;

  int          seed      = 32'h0662e5b9;
  int unsigned cycle_cnt = 0;
  int unsigned sent_cnt  = 0;
  int unsigned done_cnt  = 0;
  pending_t    pending [$];

  // Reference state that mirrors what the sequencer should hold
  vseq_pkg::vmask_t      ref_running;
  int                    ref_credit [vseq_pkg::NR_UNITS];
  vseq_pkg::vreg_entry_t ref_reader [vseq_pkg::NR_VREGS];
  vseq_pkg::vreg_entry_t ref_writer [vseq_pkg::NR_VREGS];
  vseq_pkg::vseq_issue_t exp_issue;
  logic                  exp_valid;
  logic                  accepted   = 1'b0;

  vseq_top vseq_top_i (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .req_i         (req_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .issue_o       (issue_o),
    .issue_valid_o (issue_valid_o),
    .done_i        (done_i),
    .idle_o        (idle_o)
  );

  always #HALF_PERIOD clk_i = ~clk_i;

  //////////////////////////////////////////////////////////////////////
  // Failure handling and compare tasks
  //////////////////////////////////////////////////////////////////////

  task automatic stop_on_failure();
    $display("sim failed");
    $fatal(1, "Stopping at the first failure");
  endtask

  task automatic compare_ready(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: req_ready_o is %b, expected %b", $time, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic compare_idle(input logic got, input logic exp);
    if (got !== exp) begin
      $display("ERR %0t: idle_o is %b, expected %b", $time, got, exp);
      stop_on_failure();
    end
  endtask

  // Valid is checked every cycle and the payload only with an expected issue
  task automatic compare_issue(input logic got_valid, input vseq_pkg::vseq_issue_t got,
                               input logic exp_v, input vseq_pkg::vseq_issue_t exp);
    if (got_valid !== exp_v) begin
      $display("ERR %0t: issue_valid_o is %b, expected %b", $time, got_valid, exp_v);
      stop_on_failure();
    end else if (exp_v && (got !== exp)) begin
      $display("ERR %0t: issue_o is %h, expected %h (id %0d hazard %b)",
               $time, got, exp, exp.id, exp.hazard);
      stop_on_failure();
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  function automatic vseq_pkg::unit_e decode_unit(input vseq_pkg::vop_e op);
    case (op)
      vseq_pkg::VMUL, vseq_pkg::VMACC: decode_unit = vseq_pkg::UNIT_MUL;
      vseq_pkg::VLE:                   decode_unit = vseq_pkg::UNIT_LOAD;
      vseq_pkg::VSE:                   decode_unit = vseq_pkg::UNIT_STORE;
      default:                         decode_unit = vseq_pkg::UNIT_ALU;
    endcase
  endfunction

  // RAW on the sources plus WAR and WAW on the destination
  function automatic vseq_pkg::vmask_t hazard_of(input vseq_pkg::vseq_req_t req);
    vseq_pkg::vmask_t h;
    h = '0;
    if (req.use_vs1 && ref_writer[req.vs1].valid) begin
      h[ref_writer[req.vs1].vid] = 1'b1;
    end
    if (req.use_vs2 && ref_writer[req.vs2].valid) begin
      h[ref_writer[req.vs2].vid] = 1'b1;
    end
    if (req.use_vd && ref_reader[req.vd].valid) begin
      h[ref_reader[req.vd].vid] = 1'b1;
    end
    if (req.use_vd && ref_writer[req.vd].valid) begin
      h[ref_writer[req.vd].vid] = 1'b1;
    end
    return h;
  endfunction

  // First clear bit counting up from ID 0
  function automatic vseq_pkg::vid_t lowest_free_id();
    for (int i = 0; i < vseq_pkg::NR_VINSN; i++) begin
      if (!ref_running[i]) begin
        return vseq_pkg::vid_t'(i);
      end
    end
    return '0;
  endfunction

  function automatic logic can_accept(input vseq_pkg::vseq_req_t req);
    logic stall;
    // No vector sources and any hazard at all
    stall = !req.use_vs1 && !req.use_vs2 && (|hazard_of(req));
    return !(&ref_running) && (ref_credit[decode_unit(req.op)] > 0) && !stall;
  endfunction

  function automatic vseq_pkg::vseq_issue_t expected_issue(input vseq_pkg::vseq_req_t req);
    vseq_pkg::vseq_issue_t iss;
    iss         = '0;
    iss.id      = lowest_free_id();
    iss.op      = req.op;
    iss.unit    = decode_unit(req.op);
    iss.vs1     = req.vs1;
    iss.use_vs1 = req.use_vs1;
    iss.vs2     = req.vs2;
    iss.use_vs2 = req.use_vs2;
    iss.vd      = req.vd;
    iss.use_vd  = req.use_vd;
    iss.hazard  = hazard_of(req);
    return iss;
  endfunction

  // Completions drop IDs and list entries before the accept books its ID
  task automatic update_reference(input logic acc, input vseq_pkg::vseq_issue_t iss);
    for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
      if (done_i[u].valid) begin
        ref_running[done_i[u].id] = 1'b0;
        ref_credit[u]++;
        for (int v = 0; v < vseq_pkg::NR_VREGS; v++) begin
          if (ref_reader[v].vid == done_i[u].id) begin
            ref_reader[v].valid = 1'b0;
          end
          if (ref_writer[v].vid == done_i[u].id) begin
            ref_writer[v].valid = 1'b0;
          end
        end
      end
    end
    if (acc) begin
      ref_running[iss.id] = 1'b1;
      ref_credit[iss.unit]--;
      if (iss.use_vd) begin
        ref_writer[iss.vd] = '{vid: iss.id, valid: 1'b1};
      end
      if (iss.use_vs1) begin
        ref_reader[iss.vs1] = '{vid: iss.id, valid: 1'b1};
      end
      if (iss.use_vs2) begin
        ref_reader[iss.vs2] = '{vid: iss.id, valid: 1'b1};
      end
    end
  endtask

  // Compare at the falling edge where inputs and outputs have settled
  always @(negedge clk_i) begin : p_compare
    logic exp_ready;
    if (!rst_ni) begin
      ref_running = '0;
      exp_valid   = 1'b0;
      accepted    = 1'b0;
      for (int u = 0; u < vseq_pkg::NR_UNITS; u++) begin
        ref_credit[u] = vseq_pkg::UNIT_CREDITS;
      end
      for (int v = 0; v < vseq_pkg::NR_VREGS; v++) begin
        ref_reader[v] = '0;
        ref_writer[v] = '0;
      end
    end else begin
      compare_issue(issue_valid_o, issue_o, exp_valid, exp_issue);
      compare_idle(idle_o, ref_running == '0);
      exp_ready = can_accept(req_i);
      compare_ready(req_ready_o, exp_ready);
      accepted  = req_valid_i && exp_ready;
      exp_valid = accepted;
      if (accepted) begin
        exp_issue = expected_issue(req_i);
      end
      update_reference(accepted, exp_issue);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus and unit models
  //////////////////////////////////////////////////////////////////////

  // Small register range keeps hazards frequent
  task automatic make_request(output vseq_pkg::vseq_req_t r);
    r     = '0;
    r.op  = vseq_pkg::vop_e'(4'($unsigned($random(seed)) % 9));
    r.vs1 = vseq_pkg::vreg_t'($unsigned($random(seed)) % 6);
    r.vs2 = vseq_pkg::vreg_t'($unsigned($random(seed)) % 6);
    r.vd  = vseq_pkg::vreg_t'($unsigned($random(seed)) % 6);
    case (r.op)
      // Loads and scalar moves only write vd
      vseq_pkg::VLE, vseq_pkg::VMVSX: r.use_vd = 1'b1;
      // Store data read from vs1
      vseq_pkg::VSE: r.use_vs1 = 1'b1;
      default: begin
        r.use_vs1 = 1'b1;
        r.use_vs2 = 1'b1;
        r.use_vd  = 1'b1;
      end
    endcase
  endtask

  // At most one completion per unit per cycle from any entry that is due
  task automatic drive_done();
    logic [vseq_pkg::NR_UNITS-1:0] served;
    served = '0;
    done_i = '0;
    for (int i = pending.size() - 1; i >= 0; i--) begin
      if (pending[i].due <= cycle_cnt && !served[pending[i].unit]) begin
        done_i[pending[i].unit] = '{valid: 1'b1, id: pending[i].id};
        served[pending[i].unit] = 1'b1;
        done_cnt++;
        pending.delete(i);
      end
    end
  endtask

  initial begin : p_stimulus
    vseq_pkg::vseq_req_t new_req;
    pending_t            entry;
    clk_i       = 1'b0;
    rst_ni      = 1'b0;
    req_i       = '0;
    req_valid_i = 1'b0;
    done_i      = '0;
    repeat (RESET_CYCLES) @(posedge clk_i);
    #DRIVE_DELAY;
    rst_ni = 1'b1;
    while (done_cnt < NR_REQ) begin
      @(posedge clk_i);
      #DRIVE_DELAY;
      if (accepted) begin
        sent_cnt++;
      end
      drive_done();
      // Unit takes the new instruction and finishes it 1 to 6 cycles later
      if (issue_valid_o) begin
        entry.unit = issue_o.unit;
        entry.id   = issue_o.id;
        entry.due  = cycle_cnt + 1 + ($unsigned($random(seed)) % 6);
        pending.push_back(entry);
      end
      // Request held until accepted
      if (!req_valid_i || accepted) begin
        if (sent_cnt < NR_REQ && ($unsigned($random(seed)) % 4) != 0) begin
          make_request(new_req);
          req_i       = new_req;
          req_valid_i = 1'b1;
        end else begin
          req_valid_i = 1'b0;
        end
      end
    end
    @(posedge clk_i);
    #DRIVE_DELAY;
    done_i = '0;
    repeat (2) @(posedge clk_i);
    if (idle_o && pending.size() == 0) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("Run ended with instructions still in flight");
      stop_on_failure();
    end
  end

  always @(posedge clk_i) begin : p_timeout
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("Timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      stop_on_failure();
    end
  end

endmodule

//--- flist.f
vseq_pkg.sv
vid_tracker.sv
reg_scoreboard.sv
unit_credits.sv
issue_ctrl.sv
vseq_top.sv
vseq_properties.sv
tb_vseq.sv

//--- Bender.yml
package:
  name: vseq

sources:
  - vseq_pkg.sv
  - vid_tracker.sv
  - reg_scoreboard.sv
  - unit_credits.sv
  - issue_ctrl.sv
  - vseq_top.sv
  - target: test
    files:
      - vseq_properties.sv
      - tb_vseq.sv
